// ==== src/playfield_consts.svh ====
////////////////////
// screen layout and sprite art are fixed together
// coordinates are 9 bits, sprite counts 3 bits
////////////////////
`ifndef PLAYFIELD_CONSTS_SVH
`define PLAYFIELD_CONSTS_SVH

// display
`define SCREEN_W 320
`define SCREEN_H 240
`define COORD_W 9
`define COLOR_W 12

// sprites are square
`define SPRITE_SIZE 8
`define SPRITE_BITS 3

// first ground row
`define HORIZON_Y 60

// legal left-edge columns and top-edge rows below the horizon
`define X_SPAN 313
`define Y_SPAN 173

`define POS_SEED 16'hace1

`endif

// ==== src/playfield_pkg.sv ====
////////////////////
// types shared by the painter, ROM and register block
// encodings are fixed, the testbench relies on them
////////////////////
package playfield_pkg;

	typedef enum logic [2:0] {
		st_idle,
		st_clear,
		st_place,
		st_sprite,
		st_finish
	} paint_state_e;

	typedef enum logic {
		kind_gold,
		kind_stone
	} sprite_kind_e;

	typedef enum logic [1:0] {
		cfg_gold_count,
		cfg_stone_count,
		cfg_sky_color,
		cfg_ground_color
	} cfg_addr_e;

endpackage

// ==== src/scene_regs.sv ====
////////////////////
// writes are dropped while a scene is painting
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module scene_regs (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       cfg_write,
	input  playfield_pkg::cfg_addr_e   cfg_addr,
	input  logic [`COLOR_W-1:0]        cfg_data,
	input  logic                       busy,
	output logic [2:0]                 gold_total,
	output logic [2:0]                 stone_total,
	output logic [`COLOR_W-1:0]        sky_color,
	output logic [`COLOR_W-1:0]        ground_color
);

	localparam logic [`COLOR_W-1:0] sky_reset = 12'h4af;
	localparam logic [`COLOR_W-1:0] ground_reset = 12'h642;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			gold_total <= 3'd0;
			stone_total <= 3'd0;
			sky_color <= sky_reset;
			ground_color <= ground_reset;
		end else if (cfg_write && !busy) begin
			case (cfg_addr)
				playfield_pkg::cfg_gold_count: gold_total <= cfg_data[2:0];
				playfield_pkg::cfg_stone_count: stone_total <= cfg_data[2:0];
				playfield_pkg::cfg_sky_color: sky_color <= cfg_data;
				playfield_pkg::cfg_ground_color: ground_color <= cfg_data;
			endcase
		end
	end

endmodule

// ==== src/position_lfsr.sv ====
////////////////////
// positions always keep a whole sprite on screen below the horizon
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module position_lfsr (
	input  logic                clk,
	input  logic                resetn,
	input  logic                pos_step,
	output logic [`COORD_W-1:0] sprite_x,
	output logic [`COORD_W-1:0] sprite_y
);

	typedef logic [`COORD_W-1:0] coord_t;

	localparam coord_t x_span = coord_t'(`X_SPAN);
	localparam coord_t horizon = coord_t'(`HORIZON_Y);
	localparam logic [7:0] y_span = 8'(`Y_SPAN);

	logic [15:0] lfsr_q;
	logic        feedback;
	coord_t      raw_x;
	logic [7:0]  raw_y;
	logic [7:0]  fold_y;

	// taps 16 14 13 11, shifting toward bit 0
	assign feedback = lfsr_q[0] ^ lfsr_q[2] ^ lfsr_q[3] ^ lfsr_q[5];

	always_ff @(posedge clk) begin
		if (!resetn)
			lfsr_q <= `POS_SEED;
		else if (pos_step)
			lfsr_q <= {feedback, lfsr_q[15:1]};
	end

	assign raw_x = lfsr_q[8:0];
	assign raw_y = lfsr_q[15:8];

	// one subtraction is enough, both raw ranges are under twice the span
	assign sprite_x = (raw_x >= x_span) ? raw_x - x_span : raw_x;
	assign fold_y = (raw_y >= y_span) ? raw_y - y_span : raw_y;
	assign sprite_y = horizon + {1'b0, fold_y};

endmodule

// ==== src/sprite_rom.sv ====
////////////////////
// pixel is valid one cycle after row and col
// index 0 is transparent and reads as color 0
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module sprite_rom (
	input  logic                           clk,
	input  playfield_pkg::sprite_kind_e    kind,
	input  logic [`SPRITE_BITS-1:0]        row,
	input  logic [`SPRITE_BITS-1:0]        col,
	output logic [`COLOR_W-1:0]            pix_color,
	output logic                           pix_opaque
);

	// col 0 in the top two bits of each row
	localparam logic [2*`SPRITE_SIZE-1:0] gold_art [`SPRITE_SIZE] = '{
		16'b00_00_01_01_01_00_00_00,
		16'b00_01_11_01_01_01_00_00,
		16'b01_11_01_01_10_01_01_00,
		16'b01_01_01_10_01_01_01_00,
		16'b01_01_10_01_01_11_01_01,
		16'b00_01_01_01_01_01_10_01,
		16'b00_00_10_01_01_10_01_00,
		16'b00_00_00_10_10_00_00_00
	};

	localparam logic [2*`SPRITE_SIZE-1:0] stone_art [`SPRITE_SIZE] = '{
		16'b00_00_01_01_01_01_00_00,
		16'b00_01_11_01_01_10_01_00,
		16'b01_11_01_01_10_01_01_01,
		16'b01_01_01_10_01_01_11_01,
		16'b01_10_01_01_01_01_01_01,
		16'b01_01_01_11_01_10_01_00,
		16'b00_01_10_01_01_01_10_00,
		16'b00_00_10_10_10_10_00_00
	};

	logic [2*`SPRITE_SIZE-1:0]   art_row;
	logic [3:0]                  bit_base;
	logic [1:0]                  index_q;
	playfield_pkg::sprite_kind_e kind_q;

	assign art_row = (kind == playfield_pkg::kind_gold) ? gold_art[row] : stone_art[row];
	assign bit_base = 4'd14 - {col, 1'b0};

	always_ff @(posedge clk) begin
		index_q <= art_row[bit_base +: 2];
		kind_q <= kind;
	end

	assign pix_opaque = (index_q != 2'd0);

	always_comb begin
		case (index_q)
			2'd1: pix_color = (kind_q == playfield_pkg::kind_gold) ? 12'hfd0 : 12'h888;
			2'd2: pix_color = (kind_q == playfield_pkg::kind_gold) ? 12'hb80 : 12'h555;
			2'd3: pix_color = (kind_q == playfield_pkg::kind_gold) ? 12'hffe : 12'hccc;
			default: pix_color = 12'h000;
		endcase
	end

endmodule

// ==== src/scene_painter.sv ====
////////////////////
// clears the screen, then walks gold and stone sprites
// start is ignored until done has fallen
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module scene_painter (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           start,
	input  logic [2:0]                     gold_total,
	input  logic [2:0]                     stone_total,
	input  logic [`COLOR_W-1:0]            sky_color,
	input  logic [`COLOR_W-1:0]            ground_color,
	input  logic [`COORD_W-1:0]            sprite_x,
	input  logic [`COORD_W-1:0]            sprite_y,
	input  logic [`COLOR_W-1:0]            pix_color,
	input  logic                           pix_opaque,
	output logic                           pos_step,
	output playfield_pkg::sprite_kind_e    kind,
	output logic [`SPRITE_BITS-1:0]        row,
	output logic [`SPRITE_BITS-1:0]        col,
	output logic                           plot,
	output logic [`COORD_W-1:0]            pixel_x,
	output logic [`COORD_W-1:0]            pixel_y,
	output logic [`COLOR_W-1:0]            pixel_color,
	output logic                           busy,
	output logic                           done,
	output logic [2:0]                     gold_drawn,
	output logic [2:0]                     stone_drawn
);

	typedef logic [`COORD_W-1:0] coord_t;
	typedef logic [2*`SPRITE_BITS-1:0] walk_t;

	localparam coord_t last_x = coord_t'(`SCREEN_W - 1);
	localparam coord_t last_y = coord_t'(`SCREEN_H - 1);
	localparam coord_t horizon = coord_t'(`HORIZON_Y);
	localparam walk_t last_walk = walk_t'(`SPRITE_SIZE * `SPRITE_SIZE - 1);

	playfield_pkg::paint_state_e state;

	coord_t cnt_x;
	coord_t cnt_y;
	walk_t  walk;
	logic   clear_last;
	logic   walk_last;

	// plot pipeline, one stage beside the ROM read
	logic                pipe_valid;
	logic                pipe_clear;
	coord_t              pipe_x;
	coord_t              pipe_y;
	logic [`COLOR_W-1:0] pipe_bg;

	assign clear_last = (cnt_x == last_x) && (cnt_y == last_y);
	assign walk_last = (walk == last_walk);

	assign row = walk[2*`SPRITE_BITS-1:`SPRITE_BITS];
	assign col = walk[`SPRITE_BITS-1:0];
	assign pos_step = (state == playfield_pkg::st_place);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= playfield_pkg::st_idle;
			busy <= 1'b0;
			done <= 1'b0;
			cnt_x <= '0;
			cnt_y <= '0;
			walk <= '0;
			kind <= playfield_pkg::kind_gold;
			gold_drawn <= 3'd0;
			stone_drawn <= 3'd0;
			pipe_valid <= 1'b0;
		end else begin
			done <= 1'b0;
			pipe_valid <= 1'b0;
			if (done)
				busy <= 1'b0;
			case (state)
				playfield_pkg::st_idle: begin
					if (start && !busy) begin
						state <= playfield_pkg::st_clear;
						busy <= 1'b1;
						cnt_x <= '0;
						cnt_y <= '0;
						gold_drawn <= 3'd0;
						stone_drawn <= 3'd0;
					end
				end
				playfield_pkg::st_clear: begin
					pipe_valid <= 1'b1;
					if (cnt_x == last_x) begin
						cnt_x <= '0;
						cnt_y <= cnt_y + 1'b1;
					end else begin
						cnt_x <= cnt_x + 1'b1;
					end
					if (clear_last) begin
						if (gold_total != 3'd0) begin
							kind <= playfield_pkg::kind_gold;
							state <= playfield_pkg::st_place;
						end else if (stone_total != 3'd0) begin
							kind <= playfield_pkg::kind_stone;
							state <= playfield_pkg::st_place;
						end else begin
							state <= playfield_pkg::st_finish;
						end
					end
				end
				playfield_pkg::st_place: begin
					walk <= '0;
					state <= playfield_pkg::st_sprite;
				end
				playfield_pkg::st_sprite: begin
					pipe_valid <= 1'b1;
					walk <= walk + 1'b1;
					if (walk_last) begin
						if (kind == playfield_pkg::kind_gold) begin
							gold_drawn <= gold_drawn + 3'd1;
							if (gold_drawn + 3'd1 != gold_total) begin
								state <= playfield_pkg::st_place;
							end else if (stone_total != 3'd0) begin
								kind <= playfield_pkg::kind_stone;
								state <= playfield_pkg::st_place;
							end else begin
								state <= playfield_pkg::st_finish;
							end
						end else begin
							stone_drawn <= stone_drawn + 3'd1;
							if (stone_drawn + 3'd1 != stone_total)
								state <= playfield_pkg::st_place;
							else
								state <= playfield_pkg::st_finish;
						end
					end
				end
				playfield_pkg::st_finish: begin
					// last plot leaves here, done follows
					done <= 1'b1;
					state <= playfield_pkg::st_idle;
				end
				default: state <= playfield_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		pipe_clear <= (state == playfield_pkg::st_clear);
		pipe_bg <= (cnt_y < horizon) ? sky_color : ground_color;
		if (state == playfield_pkg::st_clear) begin
			pipe_x <= cnt_x;
			pipe_y <= cnt_y;
		end else begin
			pipe_x <= sprite_x + {{(`COORD_W-`SPRITE_BITS){1'b0}}, col};
			pipe_y <= sprite_y + {{(`COORD_W-`SPRITE_BITS){1'b0}}, row};
		end
	end

	// transparent sprite pixels drop out here
	assign plot = pipe_valid && (pipe_clear || pix_opaque);
	assign pixel_x = pipe_x;
	assign pixel_y = pipe_y;
	assign pixel_color = pipe_clear ? pipe_bg : pix_color;

endmodule

// ==== src/playfield_top.sv ====
////////////////////
// plot has no back-pressure, the frame buffer must take a pixel per cycle
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module playfield_top (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       cfg_write,
	input  playfield_pkg::cfg_addr_e   cfg_addr,
	input  logic [`COLOR_W-1:0]        cfg_data,
	input  logic                       start,
	output logic                       plot,
	output logic [`COORD_W-1:0]        pixel_x,
	output logic [`COORD_W-1:0]        pixel_y,
	output logic [`COLOR_W-1:0]        pixel_color,
	output logic                       busy,
	output logic                       done,
	output logic [2:0]                 gold_drawn,
	output logic [2:0]                 stone_drawn
);

	logic [2:0]                  gold_total;
	logic [2:0]                  stone_total;
	logic [`COLOR_W-1:0]         sky_color;
	logic [`COLOR_W-1:0]         ground_color;
	logic                        pos_step;
	logic [`COORD_W-1:0]         sprite_x;
	logic [`COORD_W-1:0]         sprite_y;
	playfield_pkg::sprite_kind_e kind;
	logic [`SPRITE_BITS-1:0]     row;
	logic [`SPRITE_BITS-1:0]     col;
	logic [`COLOR_W-1:0]         pix_color;
	logic                        pix_opaque;

	scene_regs regs0 (
		.clk          (clk),
		.resetn       (resetn),
		.cfg_write    (cfg_write),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.busy         (busy),
		.gold_total   (gold_total),
		.stone_total  (stone_total),
		.sky_color    (sky_color),
		.ground_color (ground_color)
	);

	position_lfsr lfsr0 (
		.clk      (clk),
		.resetn   (resetn),
		.pos_step (pos_step),
		.sprite_x (sprite_x),
		.sprite_y (sprite_y)
	);

	sprite_rom rom0 (
		.clk        (clk),
		.kind       (kind),
		.row        (row),
		.col        (col),
		.pix_color  (pix_color),
		.pix_opaque (pix_opaque)
	);

	scene_painter painter0 (
		.clk          (clk),
		.resetn       (resetn),
		.start        (start),
		.gold_total   (gold_total),
		.stone_total  (stone_total),
		.sky_color    (sky_color),
		.ground_color (ground_color),
		.sprite_x     (sprite_x),
		.sprite_y     (sprite_y),
		.pix_color    (pix_color),
		.pix_opaque   (pix_opaque),
		.pos_step     (pos_step),
		.kind         (kind),
		.row          (row),
		.col          (col),
		.plot         (plot),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.pixel_color  (pixel_color),
		.busy         (busy),
		.done         (done),
		.gold_drawn   (gold_drawn),
		.stone_drawn  (stone_drawn)
	);

endmodule

// ==== sim/playfield_sva.sv ====
////////////////////
// protocol checks on the painter outputs, attached by bind
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module playfield_sva (
	input logic                clk,
	input logic                resetn,
	input logic                plot,
	input logic                busy,
	input logic                done,
	input logic [`COORD_W-1:0] pixel_x,
	input logic [`COORD_W-1:0] pixel_y
);

	a_plot_needs_busy: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> busy)
		else $error("plot raised while busy is low");

	// one cycle wide, and busy drops with it
	a_done_single: assert property (@(posedge clk) disable iff (!resetn)
		done |-> busy ##1 (!done && !busy))
		else $error("done not a single cycle ending together with busy");

	a_plot_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (int'(pixel_x) < `SCREEN_W) && (int'(pixel_y) < `SCREEN_H))
		else $error("plot coordinates off screen");

endmodule

bind scene_painter playfield_sva sva0 (
	.clk     (clk),
	.resetn  (resetn),
	.plot    (plot),
	.busy    (busy),
	.done    (done),
	.pixel_x (pixel_x),
	.pixel_y (pixel_y)
);

// ==== sim/playfield_tb.sv ====
////////////////////
// five scenes without a reset between them, frames compared pixel by pixel
////////////////////
`timescale 1ns/10ps
`include "playfield_consts.svh"

module playfield_tb;

	localparam int frame_size = `SCREEN_W * `SCREEN_H;
	// five scenes of at most 7 gold and 7 stone sprites
	localparam int timeout_cycles = 5 * (frame_size + 7 * 2 * 65 + 200);

	localparam logic [15:0] gold_pattern [8] = '{
		16'b00_00_01_01_01_00_00_00,
		16'b00_01_11_01_01_01_00_00,
		16'b01_11_01_01_10_01_01_00,
		16'b01_01_01_10_01_01_01_00,
		16'b01_01_10_01_01_11_01_01,
		16'b00_01_01_01_01_01_10_01,
		16'b00_00_10_01_01_10_01_00,
		16'b00_00_00_10_10_00_00_00
	};

	localparam logic [15:0] stone_pattern [8] = '{
		16'b00_00_01_01_01_01_00_00,
		16'b00_01_11_01_01_10_01_00,
		16'b01_11_01_01_10_01_01_01,
		16'b01_01_01_10_01_01_11_01,
		16'b01_10_01_01_01_01_01_01,
		16'b01_01_01_11_01_10_01_00,
		16'b00_01_10_01_01_01_10_00,
		16'b00_00_10_10_10_10_00_00
	};

	logic                     clk;
	logic                     resetn;
	logic                     cfg_write;
	playfield_pkg::cfg_addr_e cfg_addr;
	logic [`COLOR_W-1:0]      cfg_data;
	logic                     start;
	logic                     plot;
	logic [`COORD_W-1:0]      pixel_x;
	logic [`COORD_W-1:0]      pixel_y;
	logic [`COLOR_W-1:0]      pixel_color;
	logic                     busy;
	logic                     done;
	logic [2:0]               gold_drawn;
	logic [2:0]               stone_drawn;

	logic [`COLOR_W-1:0] cap_frame [frame_size];
	logic [`COLOR_W-1:0] ref_frame [frame_size];
	logic [31:0]         rnd_state = 32'h2f84_b41a;
	logic [15:0]         ref_pos;
	logic [2:0]          cfg_gold;
	logic [2:0]          cfg_stone;
	logic [`COLOR_W-1:0] cfg_sky;
	logic [`COLOR_W-1:0] cfg_ground;
	logic                done_seen = 1'b0;
	int plot_count = 0;
	int done_count = 0;
	int cycle_count = 0;
	int color_errors = 0;
	int count_errors = 0;
	int flag_errors = 0;
	int proto_errors = 0;

	playfield_top dut0 (
		.clk         (clk),
		.resetn      (resetn),
		.cfg_write   (cfg_write),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.start       (start),
		.plot        (plot),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_color (pixel_color),
		.busy        (busy),
		.done        (done),
		.gold_drawn  (gold_drawn),
		.stone_drawn (stone_drawn)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [11:0] take_bits(input int n);
		logic [11:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			rnd_state = lfsr_advance(rnd_state);
			v = {v[10:0], rnd_state[0]};
		end
		return v;
	endfunction

	function automatic logic [1:0] art_index(input playfield_pkg::sprite_kind_e k,
			input int r, input int c);
		logic [15:0] line;
		logic [15:0] shifted;
		if (k == playfield_pkg::kind_gold)
			line = gold_pattern[r];
		else
			line = stone_pattern[r];
		shifted = line >> (2 * (7 - c));
		return shifted[1:0];
	endfunction

	function automatic logic [`COLOR_W-1:0] palette(input playfield_pkg::sprite_kind_e k,
			input logic [1:0] idx);
		logic gold;
		gold = (k == playfield_pkg::kind_gold);
		case (idx)
			2'd1: return gold ? 12'hfd0 : 12'h888;
			2'd2: return gold ? 12'hb80 : 12'h555;
			2'd3: return gold ? 12'hffe : 12'hccc;
			default: return 12'h000;
		endcase
	endfunction

	// expected frame and plot count; advances the position model
	function automatic int render_scene(input logic [2:0] golds, input logic [2:0] stones,
			input logic [`COLOR_W-1:0] sky, input logic [`COLOR_W-1:0] ground);
		int plots;
		int x;
		int y;
		int n;
		int px;
		int py;
		logic [1:0] idx;
		playfield_pkg::sprite_kind_e k;
		plots = frame_size;
		for (y = 0; y < `SCREEN_H; y++)
			for (x = 0; x < `SCREEN_W; x++)
				ref_frame[y * `SCREEN_W + x] = (y < `HORIZON_Y) ? sky : ground;
		for (n = 0; n < int'(golds) + int'(stones); n++) begin
			if (n < int'(golds))
				k = playfield_pkg::kind_gold;
			else
				k = playfield_pkg::kind_stone;
			ref_pos = {ref_pos[0] ^ ref_pos[2] ^ ref_pos[3] ^ ref_pos[5], ref_pos[15:1]};
			px = int'(ref_pos[8:0]);
			if (px >= `X_SPAN)
				px = px - `X_SPAN;
			py = int'(ref_pos[15:8]);
			if (py >= `Y_SPAN)
				py = py - `Y_SPAN;
			py = py + `HORIZON_Y;
			for (y = 0; y < `SPRITE_SIZE; y++)
				for (x = 0; x < `SPRITE_SIZE; x++) begin
					idx = art_index(k, y, x);
					if (idx != 2'd0) begin
						ref_frame[(py + y) * `SCREEN_W + px + x] = palette(k, idx);
						plots++;
					end
				end
		end
		return plots;
	endfunction

	task automatic check_color(input logic [`COLOR_W-1:0] got, input logic [`COLOR_W-1:0] exp,
			input int x, input int y);
		if (got !== exp) begin
			color_errors++;
			$display("Fail %0t: pixel (%0d,%0d) is %h, expected %h", $time, x, y, got, exp);
		end
	endtask

	task automatic check_count(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp) begin
			count_errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			flag_errors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_total(input int got, input int exp, input string what);
		if (got != exp) begin
			count_errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic write_cfg(input playfield_pkg::cfg_addr_e addr, input logic [`COLOR_W-1:0] d);
		cfg_write <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= d;
		@(posedge clk);
		cfg_write <= 1'b0;
	endtask

	task automatic pulse_start();
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic random_config();
		cfg_gold = 3'(take_bits(3));
		cfg_stone = 3'(take_bits(3));
		cfg_sky = take_bits(12);
		cfg_ground = take_bits(12);
		write_cfg(playfield_pkg::cfg_gold_count, {9'd0, cfg_gold});
		write_cfg(playfield_pkg::cfg_stone_count, {9'd0, cfg_stone});
		write_cfg(playfield_pkg::cfg_sky_color, cfg_sky);
		write_cfg(playfield_pkg::cfg_ground_color, cfg_ground);
	endtask

	task automatic run_scene(input bit interfere);
		int expect_plots;
		int plots_before;
		int dones_before;
		int x;
		int y;
		expect_plots = render_scene(cfg_gold, cfg_stone, cfg_sky, cfg_ground);
		plots_before = plot_count;
		dones_before = done_count;
		pulse_start();
		if (interfere) begin
			// all of these land while busy and must be dropped
			repeat (50) @(posedge clk);
			pulse_start();
			write_cfg(playfield_pkg::cfg_gold_count, {9'd0, ~cfg_gold});
			write_cfg(playfield_pkg::cfg_sky_color, ~cfg_sky);
		end
		while (!done)
			@(posedge clk);
		check_count(gold_drawn, cfg_gold, "gold_drawn at done");
		check_count(stone_drawn, cfg_stone, "stone_drawn at done");
		@(posedge clk);
		check_flag(busy, 1'b0, "busy after done");
		check_total(plot_count - plots_before, expect_plots, "plots in scene");
		check_total(done_count - dones_before, 1, "done pulses in scene");
		for (y = 0; y < `SCREEN_H; y++)
			for (x = 0; x < `SCREEN_W; x++)
				check_color(cap_frame[y * `SCREEN_W + x], ref_frame[y * `SCREEN_W + x], x, y);
	endtask

	// frame capture and protocol watch
	always @(posedge clk) begin
		if (resetn) begin
			if (plot) begin
				plot_count <= plot_count + 1;
				if (int'(pixel_x) < `SCREEN_W && int'(pixel_y) < `SCREEN_H)
					cap_frame[int'(pixel_y) * `SCREEN_W + int'(pixel_x)] <= pixel_color;
			end
			if (done)
				done_count <= done_count + 1;
			if ((plot && !busy) || (done && !busy) || (done_seen && (done || busy)) ||
					(plot && (int'(pixel_x) >= `SCREEN_W || int'(pixel_y) >= `SCREEN_H))) begin
				proto_errors <= proto_errors + 1;
				$display("protocol error at %0t: plot, busy or done out of order", $time);
			end
			done_seen <= done;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles, the scene never finished", cycle_count);
			$display("errors: color %0d, count %0d, flag %0d, protocol %0d",
				color_errors, count_errors, flag_errors, proto_errors);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		resetn = 1'b0;
		start = 1'b0;
		cfg_write = 1'b0;
		cfg_addr = playfield_pkg::cfg_gold_count;
		cfg_data = '0;
		ref_pos = `POS_SEED;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		check_flag(plot, 1'b0, "plot after reset");
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(done, 1'b0, "done after reset");
		check_count(gold_drawn, 3'd0, "gold_drawn after reset");
		check_count(stone_drawn, 3'd0, "stone_drawn after reset");

		// background only
		cfg_gold = 3'd0;
		cfg_stone = 3'd0;
		cfg_sky = 12'h0f3;
		cfg_ground = 12'h3a9;
		write_cfg(playfield_pkg::cfg_gold_count, 12'd0);
		write_cfg(playfield_pkg::cfg_stone_count, 12'd0);
		write_cfg(playfield_pkg::cfg_sky_color, cfg_sky);
		write_cfg(playfield_pkg::cfg_ground_color, cfg_ground);
		run_scene(1'b0);

		random_config();
		run_scene(1'b0);
		random_config();
		run_scene(1'b0);
		random_config();
		run_scene(1'b1);
		// same configuration again, the dropped writes must not show
		run_scene(1'b0);

		$display("errors: color %0d, count %0d, flag %0d, protocol %0d",
			color_errors, count_errors, flag_errors, proto_errors);
		if (color_errors + count_errors + flag_errors + proto_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+src
src/playfield_pkg.sv
src/scene_regs.sv
src/position_lfsr.sv
src/sprite_rom.sv
src/scene_painter.sv
src/playfield_top.sv
sim/playfield_sva.sv
sim/playfield_tb.sv

// ==== Makefile ====
# Verilator build and run of the playfield painter testbench

VERILATOR ?= verilator
TOP ?= playfield_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
